// File: ooo_cfg.svh
`ifndef OOO_CFG_SVH
`define OOO_CFG_SVH

////////////////////
// datapath widths
////////////////////

// integer data word
`define XLEN 32

// shift amount taken from the low bits of operand b
`define SHAMT_LEN 5

// physical register tag
`define PRF_LEN 6

// reorder buffer index
`define ROB_LEN 4

////////////////////
// reservation station
////////////////////

`define RS_SIZE 4   // entries in the alu station
`define RS_LEN 2    // bits to index one entry

`endif

// File: isa_pkg.sv
`include "ooo_cfg.svh"

package isa_pkg;

    ////////////////////
    // basic words
    ////////////////////

    typedef logic [`XLEN-1:0] word_t;       // one register value
    typedef logic [`PRF_LEN-1:0] preg_t;    // physical register tag
    typedef logic [`ROB_LEN-1:0] rob_idx_t; // slot in the rob

    ////////////////////
    // alu operations
    ////////////////////

    // codes above alu_sltu are unused and give zero
    typedef enum logic [3:0] {
        alu_add  = 4'h0,
        alu_sub  = 4'h1,
        alu_and  = 4'h2,
        alu_or   = 4'h3,
        alu_xor  = 4'h4,
        alu_sll  = 4'h5,
        alu_srl  = 4'h6,
        alu_sra  = 4'h7,
        alu_slt  = 4'h8,  // signed compare
        alu_sltu = 4'h9   // unsigned compare
    } alu_func_t;

endpackage

// File: rs_pkg.sv
package rs_pkg;

    import isa_pkg::*;

    ////////////////////
    // dispatch side
    ////////////////////

    // renamed instruction from dispatch, also the station entry format
    typedef struct packed {
        word_t     pc;
        logic      opa_ready;
        preg_t     opa_tag;    // producer tag while not ready
        word_t     opa_value;
        logic      opb_ready;
        preg_t     opb_tag;
        word_t     opb_value;
        preg_t     dest_tag;
        rob_idx_t  rob_idx;
        alu_func_t alu_func;
    } dispatch_pkt_t;

    ////////////////////
    // issue and broadcast
    ////////////////////

    // operands resolved, headed for the alu
    typedef struct packed {
        word_t     pc;
        word_t     opa_value;
        word_t     opb_value;
        preg_t     dest_tag;
        rob_idx_t  rob_idx;
        alu_func_t alu_func;
    } issue_pkt_t;

    // one result on the common data bus
    typedef struct packed {
        preg_t    dest_tag;
        rob_idx_t rob_idx;
        word_t    value;
    } cdb_pkt_t;

endpackage

// File: prio_sel.sv
`timescale 1ns/1ns

module prio_sel #(
    parameter int WIDTH = 4,
    localparam int IDX_W = (WIDTH > 1) ? $clog2(WIDTH) : 1
) (
    input  logic [WIDTH-1:0] req,
    output logic [WIDTH-1:0] gnt,
    output logic [IDX_W-1:0] idx,
    output logic             empty
);

    // isolate the lowest set bit
    always_comb begin
        gnt = req & (~req + WIDTH'(1));
    end

    // scan downwards so the lowest request wins
    always_comb begin
        idx = '0;
        for (int i = WIDTH - 1; i >= 0; i--) begin
            if (req[i]) begin
                idx = IDX_W'(i);
            end
        end
    end

    assign empty = ~|req;  // nothing requested

endmodule

// File: pipe_reg.sv
`timescale 1ns/1ns

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clock,
    input  logic     arst_n,
    input  logic     flush,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     full;
    payload_t data_q;

    // accept when empty or when the held item leaves this cycle
    assign in_ready = ~full | out_ready;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            full <= 1'b0;
        end else if (flush) begin
            full <= 1'b0;
        end else if (in_valid && in_ready) begin
            full <= 1'b1;
        end else if (out_ready) begin
            full <= 1'b0;  // drained, nothing new
        end
    end

    always_ff @(posedge clock) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

    assign out_valid = full;
    assign out_data  = data_q;

endmodule

// File: rs_alu.sv
`timescale 1ns/1ns
`include "ooo_cfg.svh"

module rs_alu
    import rs_pkg::*;
(
    input  logic          clock,
    input  logic          arst_n,
    input  logic          flush,
    input  logic          dispatch_valid,
    output logic          dispatch_ready,
    input  dispatch_pkt_t dispatch_pkt,
    input  logic          wake_a_valid,
    input  cdb_pkt_t      wake_a,
    input  logic          wake_b_valid,
    input  cdb_pkt_t      wake_b,
    output logic          issue_valid,
    input  logic          issue_ready,
    output issue_pkt_t    issue_pkt
);

    dispatch_pkt_t         entries [`RS_SIZE];
    logic [`RS_SIZE-1:0]   busy;
    logic [`RS_LEN:0]      count;      // occupied entries
    logic [`RS_SIZE-1:0]   free_req;
    logic [`RS_SIZE-1:0]   free_gnt;
    logic [`RS_LEN-1:0]    free_idx;
    logic                  free_empty;
    logic [`RS_SIZE-1:0]   ready_req;
    logic [`RS_SIZE-1:0]   ready_gnt;
    logic [`RS_LEN-1:0]    ready_idx;
    logic                  ready_empty;
    logic                  do_dispatch;
    logic                  issue_fire;
    dispatch_pkt_t         sel;

    // tag compare of both operands against the two broadcast ports
    function automatic dispatch_pkt_t wake(dispatch_pkt_t e);
        dispatch_pkt_t r;
        r = e;
        if (!e.opa_ready && wake_a_valid && e.opa_tag == wake_a.dest_tag) begin
            r.opa_ready = 1'b1;
            r.opa_value = wake_a.value;
        end
        if (!e.opa_ready && wake_b_valid && e.opa_tag == wake_b.dest_tag) begin
            r.opa_ready = 1'b1;
            r.opa_value = wake_b.value;
        end
        if (!e.opb_ready && wake_a_valid && e.opb_tag == wake_a.dest_tag) begin
            r.opb_ready = 1'b1;
            r.opb_value = wake_a.value;
        end
        if (!e.opb_ready && wake_b_valid && e.opb_tag == wake_b.dest_tag) begin
            r.opb_ready = 1'b1;
            r.opb_value = wake_b.value;
        end
        return r;
    endfunction

    ////////////////////
    // slot selection
    ////////////////////

    always_comb begin
        for (int i = 0; i < `RS_SIZE; i++) begin
            free_req[i]  = ~busy[i];
            ready_req[i] = busy[i] & entries[i].opa_ready & entries[i].opb_ready;
        end
    end

    prio_sel #(.WIDTH(`RS_SIZE)) i_free_sel (
        .req   (free_req),
        .gnt   (free_gnt),
        .idx   (free_idx),
        .empty (free_empty)
    );

    prio_sel #(.WIDTH(`RS_SIZE)) i_ready_sel (
        .req   (ready_req),
        .gnt   (ready_gnt),
        .idx   (ready_idx),
        .empty (ready_empty)
    );

    // full means full, a slot leaving this cycle is not reused yet
    assign dispatch_ready = (count != (`RS_LEN+1)'(`RS_SIZE));
    assign do_dispatch    = dispatch_valid & dispatch_ready & ~free_empty;
    assign issue_valid    = ~ready_empty;
    assign issue_fire     = issue_valid & issue_ready;

    ////////////////////
    // control state
    ////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            busy  <= '0;
            count <= '0;
        end else if (flush) begin
            busy  <= '0;
            count <= '0;
        end else begin
            busy <= (busy & ~(issue_fire ? ready_gnt : '0))
                  | (do_dispatch ? free_gnt : '0);
            case ({do_dispatch, issue_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // none or both
            endcase
        end
    end

    ////////////////////
    // entry payload
    ////////////////////

    always_ff @(posedge clock) begin
        for (int i = 0; i < `RS_SIZE; i++) begin
            if (do_dispatch && i == int'(free_idx)) begin
                entries[i] <= wake(dispatch_pkt);  // same-cycle broadcast caught here
            end else begin
                entries[i] <= wake(entries[i]);
            end
        end
    end

    // operands of the chosen entry
    assign sel = entries[ready_idx];

    always_comb begin
        issue_pkt.pc        = sel.pc;
        issue_pkt.opa_value = sel.opa_value;
        issue_pkt.opb_value = sel.opb_value;
        issue_pkt.dest_tag  = sel.dest_tag;
        issue_pkt.rob_idx   = sel.rob_idx;
        issue_pkt.alu_func  = sel.alu_func;
    end

endmodule

// File: alu_exec.sv
`timescale 1ns/1ns
`include "ooo_cfg.svh"

module alu_exec
    import isa_pkg::*, rs_pkg::*;
(
    input  logic       clock,
    input  logic       arst_n,
    input  logic       flush,
    input  logic       issue_valid,
    output logic       issue_ready,
    input  issue_pkt_t issue_pkt,
    output logic       result_valid,
    input  logic       result_ready,
    output cdb_pkt_t   result
);

    word_t                 a;
    word_t                 b;
    word_t                 value;
    logic [`SHAMT_LEN-1:0] shamt;
    cdb_pkt_t              res_pkt;

    assign a     = issue_pkt.opa_value;
    assign b     = issue_pkt.opb_value;
    assign shamt = b[`SHAMT_LEN-1:0];

    always_comb begin
        case (issue_pkt.alu_func)
            alu_add:  value = a + b;
            alu_sub:  value = a - b;
            alu_and:  value = a & b;
            alu_or:   value = a | b;
            alu_xor:  value = a ^ b;
            alu_sll:  value = a << shamt;
            alu_srl:  value = a >> shamt;
            alu_sra:  value = word_t'($signed(a) >>> shamt);
            alu_slt:  value = word_t'($signed(a) < $signed(b));
            alu_sltu: value = word_t'(a < b);
            default:  value = '0;
        endcase
    end

    // result packet for the cdb
    always_comb begin
        res_pkt.dest_tag = issue_pkt.dest_tag;
        res_pkt.rob_idx  = issue_pkt.rob_idx;
        res_pkt.value    = value;
    end

    pipe_reg #(.payload_t(cdb_pkt_t)) i_result_reg (
        .clock     (clock),
        .arst_n    (arst_n),
        .flush     (flush),
        .in_valid  (issue_valid),
        .in_ready  (issue_ready),
        .in_data   (res_pkt),
        .out_valid (result_valid),
        .out_ready (result_ready),
        .out_data  (result)
    );

endmodule

// File: alu_issue_top.sv
`timescale 1ns/1ns

module alu_issue_top
    import rs_pkg::*;
(
    input  logic          clock,
    input  logic          arst_n,
    input  logic          flush,
    input  logic          dispatch_valid,
    output logic          dispatch_ready,
    input  dispatch_pkt_t dispatch_pkt,
    input  logic          ext_cdb_valid,
    input  cdb_pkt_t      ext_cdb,
    output logic          result_valid,
    input  logic          result_ready,
    output cdb_pkt_t      result
);

    logic       issue_valid;
    logic       issue_ready;
    issue_pkt_t issue_pkt;
    logic       own_wake_valid;

    // own result counts only once it actually leaves
    assign own_wake_valid = result_valid & result_ready;

    rs_alu i_rs_alu (
        .clock          (clock),
        .arst_n         (arst_n),
        .flush          (flush),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .dispatch_pkt   (dispatch_pkt),
        .wake_a_valid   (own_wake_valid),
        .wake_a         (result),
        .wake_b_valid   (ext_cdb_valid),   // other units, already granted
        .wake_b         (ext_cdb),
        .issue_valid    (issue_valid),
        .issue_ready    (issue_ready),
        .issue_pkt      (issue_pkt)
    );

    alu_exec i_alu_exec (
        .clock        (clock),
        .arst_n       (arst_n),
        .flush        (flush),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready),
        .issue_pkt    (issue_pkt),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result       (result)
    );

endmodule

// File: alu_issue_properties.sv
`timescale 1ns/1ns
`include "ooo_cfg.svh"

module alu_issue_properties
    import rs_pkg::*;
(
    input logic                clock,
    input logic                arst_n,
    input logic                flush,
    input logic                dispatch_valid,
    input logic                dispatch_ready,
    input dispatch_pkt_t       dispatch_pkt,
    input logic                issue_valid,
    input logic                issue_ready,
    input logic                result_valid,
    input logic                result_ready,
    input cdb_pkt_t            result,
    input logic [`RS_SIZE-1:0] rs_busy
);

    int   fail_count = 0;
    logic fast_start;   // ready instruction into an empty slice

    assign fast_start = dispatch_valid && dispatch_ready && dispatch_pkt.opa_ready
                     && dispatch_pkt.opb_ready && rs_busy == '0 && !result_valid && !flush;

    ////////////////////
    // reset and flush
    ////////////////////

    clear_after_flush: assert property (@(posedge clock)
        ($past(!arst_n) || $past(flush)) |-> dispatch_ready && !issue_valid && !result_valid)
        else begin
            fail_count++;
            $error("slice not idle after reset or flush");
        end

    ////////////////////
    // handshakes
    ////////////////////

    hold_result: assert property (@(posedge clock) disable iff (!arst_n)
        result_valid && !result_ready && !flush |=> result_valid && $stable(result))
        else begin
            fail_count++;
            $error("result changed while stalled");
        end

    // a ready entry stays ready until it goes
    hold_issue: assert property (@(posedge clock) disable iff (!arst_n)
        issue_valid && !issue_ready && !flush |=> issue_valid)
        else begin
            fail_count++;
            $error("issue_valid dropped without handshake");
        end

    full_blocks: assert property (@(posedge clock) disable iff (!arst_n)
        (&rs_busy) |-> !dispatch_ready)
        else begin
            fail_count++;
            $error("dispatch_ready high with station full");
        end

    ////////////////////
    // latency
    ////////////////////

    fast_not_early: assert property (@(posedge clock) disable iff (!arst_n)
        $past(fast_start) |-> !result_valid)
        else begin
            fail_count++;
            $error("result one cycle after dispatch");
        end

    fast_on_time: assert property (@(posedge clock) disable iff (!arst_n)
        $past(fast_start, 2) && !$past(flush) |-> result_valid)
        else begin
            fail_count++;
            $error("result missing two cycles after dispatch");
        end

endmodule

bind alu_issue_top alu_issue_properties i_alu_issue_properties (
    .clock          (clock),
    .arst_n         (arst_n),
    .flush          (flush),
    .dispatch_valid (dispatch_valid),
    .dispatch_ready (dispatch_ready),
    .dispatch_pkt   (dispatch_pkt),
    .issue_valid    (issue_valid),
    .issue_ready    (issue_ready),
    .result_valid   (result_valid),
    .result_ready   (result_ready),
    .result         (result),
    .rs_busy        (i_rs_alu.busy)
);

// File: tb_alu_issue.sv
`timescale 1ns/1ns

module tb_alu_issue
    import isa_pkg::*, rs_pkg::*;
();

    localparam int TIMEOUT = 200;   // cycles per wait loop

    logic          clock;
    logic          arst_n;
    logic          flush;
    logic          dispatch_valid;
    logic          dispatch_ready;
    dispatch_pkt_t dispatch_pkt;
    logic          ext_cdb_valid;
    cdb_pkt_t      ext_cdb;
    logic          result_valid;
    logic          result_ready;
    cdb_pkt_t      result;

    logic [15:0] lfsr;
    word_t       ext_val [64];     // values of the external producers
    word_t       exp_value [16];
    preg_t       exp_tag [16];
    logic [15:0] pending;          // rob indices still owed a result
    int          done_count;
    int          next_rob;
    int          next_ext;
    rob_idx_t    last_rob;
    logic        auto_bcast;       // drain ext_q on random cycles
    logic        backpressure;     // random result_ready
    preg_t       ext_q [$];

    alu_issue_top i_alu_issue_top (.*);

    always #20 clock = ~clock;

    ////////////////////
    // helpers
    ////////////////////

    task automatic abort_run(string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_equal(string name, word_t expected, word_t actual);
        assert (expected === actual) else begin
            abort_run($sformatf("FAIL time=%0t %s expected=%h actual=%h",
                                $time, name, expected, actual));
        end
    endtask

    // fibonacci lfsr with taps 16 14 13 11
    function automatic word_t rand_bits(int n);
        word_t r;
        logic  fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic word_t ref_alu(alu_func_t f, word_t a, word_t b);
        logic [4:0] s;
        word_t      ones;
        word_t      fill;
        s    = b[4:0];
        ones = '1;
        fill = a[31] ? ~(ones >> s) : '0;  // sign bits shifted in
        case (f)
            alu_add:  return a + b;
            alu_sub:  return a + ~b + 32'd1;
            alu_and:  return a & b;
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            alu_sll:  return a << s;
            alu_srl:  return a >> s;
            alu_sra:  return (a >> s) | fill;
            alu_slt:  return (a[31] != b[31]) ? word_t'(a[31]) : word_t'(a < b);
            alu_sltu: return word_t'(a < b);
            default:  return '0;
        endcase
    endfunction

    // advance to the next falling edge and drive the background inputs
    task automatic next_cycle();
        preg_t t;
        @(negedge clock);
        ext_cdb_valid = 1'b0;
        if (backpressure) begin
            result_ready = (rand_bits(1) != 0);
        end
        if (auto_bcast && ext_q.size() > 0 && rand_bits(1) != 0) begin
            t             = ext_q.pop_front();
            ext_cdb       = '{dest_tag: t, rob_idx: '0, value: ext_val[t]};
            ext_cdb_valid = 1'b1;
        end
    endtask

    task automatic wait_done(int target);
        for (int w = 0; done_count < target; w++) begin
            if (w > TIMEOUT) abort_run("expected results did not arrive in time");
            next_cycle();
        end
    endtask

    // a_val and b_val are the true operand values even for waiting operands
    task automatic dispatch_instr(alu_func_t f, logic a_rdy, preg_t a_tag, word_t a_val,
                                  logic b_rdy, preg_t b_tag, word_t b_val);
        dispatch_pkt_t p;
        rob_idx_t      rob;
        logic          fired;
        rob = rob_idx_t'(next_rob);
        for (int w = 0; pending[rob]; w++) begin
            if (w > TIMEOUT) abort_run("rob index never completed");
            next_cycle();
        end
        p.pc        = word_t'(next_rob) << 2;
        p.opa_ready = a_rdy;
        p.opa_tag   = a_tag;
        p.opa_value = a_rdy ? a_val : ~a_val;  // junk until woken
        p.opb_ready = b_rdy;
        p.opb_tag   = b_tag;
        p.opb_value = b_rdy ? b_val : ~b_val;
        p.dest_tag  = preg_t'(48) + preg_t'(rob);
        p.rob_idx   = rob;
        p.alu_func  = f;
        exp_value[rob] = ref_alu(f, a_val, b_val);
        exp_tag[rob]   = p.dest_tag;
        last_rob       = rob;
        dispatch_pkt   = p;
        dispatch_valid = 1'b1;
        fired          = 1'b0;
        for (int w = 0; !fired; w++) begin
            @(posedge clock);
            fired = dispatch_ready;
            if (!fired) begin
                if (w > TIMEOUT) abort_run("dispatch_ready stayed low");
                next_cycle();
            end
        end
        pending[rob] = 1'b1;
        if (auto_bcast && !a_rdy) ext_q.push_back(a_tag);
        if (auto_bcast && !b_rdy) ext_q.push_back(b_tag);
        next_rob++;
        next_cycle();
        dispatch_valid = 1'b0;
    endtask

    ////////////////////
    // result scoreboard
    ////////////////////

    always @(posedge clock) begin
        if (arst_n && result_valid && result_ready) begin
            if (!pending[result.rob_idx]) begin
                abort_run($sformatf("unexpected result for rob index %0d", result.rob_idx));
            end
            check_equal("result.value", exp_value[result.rob_idx], result.value);
            check_equal("result.dest_tag", word_t'(exp_tag[result.rob_idx]),
                        word_t'(result.dest_tag));
            pending[result.rob_idx] = 1'b0;
            done_count++;
        end
        if (i_alu_issue_top.i_alu_issue_properties.fail_count != 0) begin
            abort_run("a protocol assertion on the issue slice failed");
        end
    end

    ////////////////////
    // stimulus
    ////////////////////

    initial begin
        int    base;
        preg_t t1;
        preg_t t2;
        logic  a_rdy;
        logic  b_rdy;
        preg_t ta;
        preg_t tb;
        clock          = 1'b0;
        arst_n         = 1'b0;
        flush          = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_pkt   = '0;
        ext_cdb_valid  = 1'b0;
        ext_cdb        = '0;
        result_ready   = 1'b1;
        lfsr           = 16'd54667;
        pending        = '0;
        done_count     = 0;
        next_rob       = 0;
        next_ext       = 1;   // tags 1..47 external, 48..63 own
        auto_bcast     = 1'b0;
        backpressure   = 1'b0;
        for (int t = 0; t < 64; t++) begin
            ext_val[t] = rand_bits(32);
        end
        repeat (2) @(negedge clock);
        arst_n = 1'b1;

        // every alu code alone on an empty slice
        for (int f = 0; f < 10; f++) begin
            dispatch_instr(alu_func_t'(f), 1'b1, '0, rand_bits(32), 1'b1, '0, rand_bits(32));
            wait_done(done_count + 1);
        end

        // chain through own results with one tag broadcast in the dispatch cycle
        t1       = preg_t'(next_ext);
        t2       = preg_t'(next_ext + 1);
        next_ext = next_ext + 2;
        base     = done_count;
        dispatch_instr(alu_add, 1'b0, t1, ext_val[t1], 1'b1, '0, rand_bits(32));
        ext_cdb       = '{dest_tag: t2, rob_idx: '0, value: ext_val[t2]};
        ext_cdb_valid = 1'b1;
        dispatch_instr(alu_xor, 1'b0, exp_tag[last_rob], exp_value[last_rob],
                       1'b0, t2, ext_val[t2]);
        dispatch_instr(alu_sub, 1'b0, exp_tag[last_rob], exp_value[last_rob],
                       1'b0, exp_tag[last_rob], exp_value[last_rob]);
        for (int w = 0; w < 8; w++) begin
            next_cycle();
            check_equal("done_count", word_t'(base), word_t'(done_count));
        end
        ext_cdb       = '{dest_tag: t1, rob_idx: '0, value: ext_val[t1]};
        ext_cdb_valid = 1'b1;
        wait_done(base + 3);

        // stalled result fills the station
        result_ready = 1'b0;
        base         = done_count;
        repeat (5) begin
            dispatch_instr(alu_func_t'(4'(rand_bits(4) % 10)), 1'b1, '0, rand_bits(32),
                           1'b1, '0, rand_bits(32));
        end
        @(posedge clock);
        check_equal("dispatch_ready", '0, word_t'(dispatch_ready));
        next_cycle();
        result_ready = 1'b1;
        wait_done(base + 5);

        // flush with one result held and two entries waiting
        result_ready = 1'b0;
        dispatch_instr(alu_or, 1'b1, '0, rand_bits(32), 1'b1, '0, rand_bits(32));
        dispatch_instr(alu_and, 1'b0, preg_t'(next_ext), '0, 1'b1, '0, rand_bits(32));
        dispatch_instr(alu_sll, 1'b1, '0, rand_bits(32), 1'b0, preg_t'(next_ext + 1), '0);
        next_ext = next_ext + 2;   // broadcast only after the flush
        flush    = 1'b1;
        pending  = '0;
        next_cycle();
        flush        = 1'b0;
        result_ready = 1'b1;
        base         = done_count;
        for (int w = 0; w < 10; w++) begin
            if (w < 2) begin
                // stale waiting entries would wake on these
                ext_cdb       = '{dest_tag: preg_t'(next_ext - 2 + w), rob_idx: '0, value: '0};
                ext_cdb_valid = 1'b1;
            end
            next_cycle();
            check_equal("done_count", word_t'(base), word_t'(done_count));
        end

        // random traffic with back-pressure
        backpressure = 1'b1;
        auto_bcast   = 1'b1;
        repeat (30) begin
            a_rdy = (next_ext >= 47) || (rand_bits(1) != 0);
            ta    = a_rdy ? '0 : preg_t'(next_ext);
            if (!a_rdy) next_ext++;
            b_rdy = (next_ext >= 47) || (rand_bits(1) != 0);
            tb    = b_rdy ? '0 : preg_t'(next_ext);
            if (!b_rdy) next_ext++;
            dispatch_instr(alu_func_t'(4'(rand_bits(4) % 10)),
                           a_rdy, ta, a_rdy ? rand_bits(32) : ext_val[ta],
                           b_rdy, tb, b_rdy ? rand_bits(32) : ext_val[tb]);
        end
        backpressure = 1'b0;
        result_ready = 1'b1;
        for (int w = 0; pending != '0; w++) begin
            if (w > TIMEOUT) abort_run("instructions left in flight at the end");
            next_cycle();
        end

        if (i_alu_issue_top.i_alu_issue_properties.fail_count == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            abort_run("a protocol assertion failed near the end of the run");
        end
    end

endmodule

// File: sources.f
+incdir+.
isa_pkg.sv
rs_pkg.sv
prio_sel.sv
pipe_reg.sv
rs_alu.sv
alu_exec.sv
alu_issue_top.sv
alu_issue_properties.sv
tb_alu_issue.sv

// File: Makefile
TOP := tb_alu_issue

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ns -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns -f sources.f --top-module $(TOP)
	out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir
